//--- sources.f
cpu_pkg.sv
mem_arbiter.sv
prog_ram.sv
stack_engine.sv
cpu_seq.sv
cpu_ctrl.sv
cpu_top.sv
tb_cpu.sv

//--- Bender.yml
# control path of an 8-bit accumulator CPU with shared program RAM.
package:
  name: acc_cpu

sources:
  - cpu_pkg.sv
  - mem_arbiter.sv
  - prog_ram.sv
  - stack_engine.sv
  - cpu_seq.sv
  - cpu_ctrl.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu.sv

//--- tb_cpu.sv
// runs six short programs from address 0, each ending in a branch to itself; RAM depth 1024 assumed.
`timescale 1ns/1ps

module tb_cpu;

    localparam int PROG_BYTES = 98;                    // six programs together.
    localparam int TIMEOUT    = 4 * PROG_BYTES + 200;  // in clock cycles.

    logic              clk;
    logic              rst;
    logic              run;
    logic              host_vld;
    cpu_pkg::mem_req_t host_req;
    cpu_pkg::regs_t    regs;
    cpu_pkg::addr_t    pc;
    logic              retire;
    cpu_pkg::retire_t  retired;

    cpu_pkg::data_t    image [1024]; // what the RAM should hold.
    cpu_pkg::data_t    prog [$];     // program being built.
    cpu_pkg::regs_t    exp_regs;
    cpu_pkg::addr_t    exp_pc;       // opcode address of the next retire.
    cpu_pkg::data_t    exp_op;
    cpu_pkg::addr_t    exp_fall;     // address after the whole instruction.
    cpu_pkg::addr_t    end_addr;
    logic              end_seen;
    logic [31:0]       seed;
    string             test_name;
    int                errors;
    int                err_mark;
    int                n_pass;
    int                n_fail;
    int                cycle_cnt;
    cpu_pkg::data_t    x;

    cpu_top #(.RAM_DEPTH(1024), .N_REQ(3)) cpu_top_i (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .run      ( run      ),
        .host_vld ( host_vld ),
        .host_req ( host_req ),
        .regs     ( regs     ),
        .pc       ( pc       ),
        .retire   ( retire   ),
        .retired  ( retired  )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cpu_pkg::data_t rand_byte();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[23:16];
    endfunction

    // bytes per instruction, opcode included.
    function automatic int instr_len(cpu_pkg::data_t op);
        case (op)
            cpu_pkg::OP_JMP: return 3;
            cpu_pkg::OP_LDA, cpu_pkg::OP_LDB, cpu_pkg::OP_BRA, cpu_pkg::OP_BEQ,
            cpu_pkg::OP_BNE, cpu_pkg::OP_PSH, cpu_pkg::OP_PUL: return 2;
            default: return 1;
        endcase
    endfunction

    assign exp_op   = image[exp_pc[9:0]];
    assign exp_fall = exp_pc + 16'(instr_len(exp_op));

    // ########################################################################
    // reference model, steps once per retire
    // ########################################################################
    always @(posedge clk or posedge rst) begin : model
        cpu_pkg::regs_t nr;
        cpu_pkg::addr_t sp;
        cpu_pkg::addr_t nxt;
        cpu_pkg::data_t b1;
        cpu_pkg::data_t b2;
        cpu_pkg::data_t total;
        logic           take;
        if (rst) begin
            exp_regs <= '{a: 8'h00, b: 8'h00, cc: 8'h00, s: cpu_pkg::STACK_TOP};
            exp_pc   <= '0;
            end_seen <= 1'b0;
        end else if (retire) begin
            nr   = exp_regs;
            nxt  = exp_fall;
            take = 1'b0;
            sp   = exp_pc + 16'd1;
            b1   = image[sp[9:0]];
            sp   = exp_pc + 16'd2;
            b2   = image[sp[9:0]];
            sp   = exp_regs.s;
            case (exp_op)
                cpu_pkg::OP_LDA: nr.a = b1;
                cpu_pkg::OP_LDB: nr.b = b1;
                cpu_pkg::OP_ADD: begin
                    total                = exp_regs.a + exp_regs.b;
                    nr.a                 = total;
                    nr.cc[cpu_pkg::CC_Z] = (total == 8'h00);
                    nr.cc[cpu_pkg::CC_N] = total[7];
                end
                cpu_pkg::OP_BRA: take = 1'b1;
                cpu_pkg::OP_BEQ: take = exp_regs.cc[cpu_pkg::CC_Z];
                cpu_pkg::OP_BNE: take = !exp_regs.cc[cpu_pkg::CC_Z];
                cpu_pkg::OP_JMP: nxt = {b1, b2}; // high byte first.
                cpu_pkg::OP_PSH: begin
                    if (b1[2]) begin
                        sp = sp - 16'd1;
                        image[sp[9:0]] = exp_regs.b;
                    end
                    if (b1[1]) begin
                        sp = sp - 16'd1;
                        image[sp[9:0]] = exp_regs.a;
                    end
                    if (b1[0]) begin
                        sp = sp - 16'd1;
                        image[sp[9:0]] = exp_regs.cc;
                    end
                    nr.s = sp;
                end
                cpu_pkg::OP_PUL: begin
                    if (b1[0]) begin
                        nr.cc = image[sp[9:0]];
                        sp    = sp + 16'd1;
                    end
                    if (b1[1]) begin
                        nr.a = image[sp[9:0]];
                        sp   = sp + 16'd1;
                    end
                    if (b1[2]) begin
                        nr.b = image[sp[9:0]];
                        sp   = sp + 16'd1;
                    end
                    nr.s = sp;
                end
                default: ; // undefined bytes act as one-byte NOP.
            endcase
            if (take) nxt = exp_fall + {{8{b1[7]}}, b1}; // relative to the next opcode.
            exp_regs <= nr;
            exp_pc   <= nxt;
            if (retired.pc == end_addr) end_seen <= 1'b1;
        end
    end

    // ########################################################################
    // checks
    // ########################################################################
    a_retired : assert property (@(posedge clk) disable iff (rst)
        retire |-> retired == {exp_pc, exp_op})
        else begin
            errors++;
            $display("Error %s: retired expected %h actual %h", test_name,
                     {$sampled(exp_pc), $sampled(exp_op)}, $sampled(retired));
        end

    a_pc_after : assert property (@(posedge clk) disable iff (rst)
        retire |-> pc == exp_fall)
        else begin
            errors++;
            $display("Error %s: pc expected %h actual %h", test_name,
                     $sampled(exp_fall), $sampled(pc));
        end

    a_regs : assert property (@(posedge clk) disable iff (rst) regs == exp_regs)
        else begin
            errors++;
            $display("Error %s: regs expected %h actual %h", test_name,
                     $sampled(exp_regs), $sampled(regs));
        end

    // every program pulls exactly what it pushed.
    a_stack_top : assert property (@(posedge clk) disable iff (rst)
        (retire && retired.op == cpu_pkg::OP_PUL) |=> regs.s == cpu_pkg::STACK_TOP)
        else begin
            errors++;
            $display("Error %s: s expected %h actual %h", test_name,
                     cpu_pkg::STACK_TOP, $sampled(regs.s));
        end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout in test %s: no finish within %0d cycles", test_name, TIMEOUT);
        $display("=== FAIL ===");
        $finish;
    end

    // ########################################################################
    // stimulus helpers
    // ########################################################################
    task automatic drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic emit(input cpu_pkg::data_t b);
        prog.push_back(b);
    endtask

    task automatic emit2(input cpu_pkg::data_t op, input cpu_pkg::data_t b);
        emit(op);
        emit(b);
    endtask

    // random forward offset of one to three into three NOPs, so both paths meet again.
    task automatic emit_branch(input cpu_pkg::data_t op);
        emit2(op, 8'd1 + rand_byte() % 8'd3);
        repeat (3) emit(cpu_pkg::OP_NOP);
    endtask

    task automatic finish_program();
        end_addr = 16'(prog.size());
        emit2(cpu_pkg::OP_BRA, 8'hfe); // branch to itself.
    endtask

    task automatic load_segment(input cpu_pkg::addr_t base);
        cpu_pkg::addr_t a;
        foreach (prog[i]) begin
            a = base + 16'(i);
            drive_slot();
            host_vld = 1'b1;
            host_req = '{we: 1'b1, addr: a, wdata: prog[i]};
            image[a[9:0]] = prog[i];
        end
        drive_slot();
        host_vld = 1'b0;
        prog.delete();
    endtask

    task automatic host_traffic(input int n);
        cpu_pkg::addr_t a;
        for (int i = 0; i < n; i++) begin
            a = 16'h0200 + 16'(i); // well away from the code.
            drive_slot();
            host_vld = 1'b1;
            host_req = '{we: 1'b1, addr: a, wdata: rand_byte()};
            image[a[9:0]] = host_req.wdata;
            drive_slot();
            host_vld = 1'b0;
        end
    endtask

    task automatic run_program();
        drive_slot();
        run = 1'b1;
        while (!end_seen) begin
            @(posedge clk);
        end
        #2;
        run = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
        drive_slot();
        rst = 1'b1;
        run = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: passed", test_name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    // ########################################################################
    // tests
    // ########################################################################
    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        host_vld  = 1'b0;
        host_req  = '0;
        seed      = 32'hec9031f1;
        end_addr  = '0;
        errors    = 0;
        n_pass    = 0;
        n_fail    = 0;
        test_name = "reset";

        start_test("lda_ldb_add");
        for (int i = 0; i < 2; i++) begin
            emit2(cpu_pkg::OP_LDA, rand_byte());
            emit2(cpu_pkg::OP_LDB, rand_byte());
            emit(cpu_pkg::OP_ADD);
        end
        x = rand_byte();
        emit2(cpu_pkg::OP_LDA, x);
        emit2(cpu_pkg::OP_LDB, 8'h00 - x); // sum wraps to zero.
        emit(cpu_pkg::OP_ADD);
        finish_program();
        load_segment(16'h0000);
        run_program();
        end_test();

        start_test("beq_bne");
        emit2(cpu_pkg::OP_LDA, 8'h00);
        emit2(cpu_pkg::OP_LDB, 8'h00);
        emit(cpu_pkg::OP_ADD);             // z set.
        emit_branch(cpu_pkg::OP_BEQ);
        emit_branch(cpu_pkg::OP_BNE);
        emit2(cpu_pkg::OP_LDA, 8'h01);
        emit(cpu_pkg::OP_ADD);             // z clear.
        emit_branch(cpu_pkg::OP_BEQ);
        emit_branch(cpu_pkg::OP_BNE);
        finish_program();
        load_segment(16'h0000);
        run_program();
        end_test();

        start_test("jmp_bra_back");
        emit(cpu_pkg::OP_JMP);
        emit(8'h00);
        emit(8'h10);
        emit2(cpu_pkg::OP_LDB, rand_byte());
        finish_program();
        load_segment(16'h0000);
        emit2(cpu_pkg::OP_LDA, rand_byte());
        emit2(cpu_pkg::OP_BRA, 8'hef);     // back to 16'h0003.
        load_segment(16'h0010);
        run_program();
        end_test();

        start_test("psh_pul");
        x = rand_byte();
        emit2(cpu_pkg::OP_LDA, x);
        emit2(cpu_pkg::OP_LDB, 8'h80 - x); // sum 8'h80, n set.
        emit(cpu_pkg::OP_ADD);
        emit2(cpu_pkg::OP_PSH, 8'h07);
        emit2(cpu_pkg::OP_LDA, ~x);
        emit2(cpu_pkg::OP_LDB, x + 8'h01); // zero sum moves a, b and cc off the pushed values.
        emit(cpu_pkg::OP_ADD);
        emit2(cpu_pkg::OP_PUL, 8'h07);
        finish_program();
        load_segment(16'h0000);
        run_program();
        end_test();

        start_test("host_during_run");
        emit2(cpu_pkg::OP_LDA, rand_byte());
        emit2(cpu_pkg::OP_LDB, rand_byte());
        emit(cpu_pkg::OP_ADD);
        emit2(cpu_pkg::OP_LDA, rand_byte());
        emit(cpu_pkg::OP_ADD);
        emit(cpu_pkg::OP_NOP);
        emit(cpu_pkg::OP_NOP);
        emit2(cpu_pkg::OP_LDB, rand_byte());
        emit(cpu_pkg::OP_ADD);
        finish_program();
        load_segment(16'h0000);
        fork
            run_program();
            host_traffic(12);
        join
        end_test();

        start_test("undefined_opcode");
        emit2(cpu_pkg::OP_LDA, rand_byte());
        emit(8'h01);
        emit(8'hff);
        emit2(cpu_pkg::OP_LDB, rand_byte());
        emit(8'h55);
        finish_program();
        load_segment(16'h0000);
        run_program();
        end_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_pass + n_fail, n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- cpu_top.sv
// CPU with shared RAM; N_REQ must stay 3 (host, stack, fetch) and the host port only writes.
`timescale 1ns/1ps

module cpu_top #(
    parameter int RAM_DEPTH = 1024,
    parameter int N_REQ     = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic              host_vld,
    input  cpu_pkg::mem_req_t host_req,
    output cpu_pkg::regs_t    regs,
    output cpu_pkg::addr_t    pc,
    output logic              retire,
    output cpu_pkg::retire_t  retired
);

    logic [N_REQ-1:0]  req_vld;
    logic [N_REQ-1:0]  gnt;
    logic [N_REQ-1:0]  rvld;
    cpu_pkg::mem_req_t reqs [N_REQ];
    cpu_pkg::mem_req_t mem_req;
    logic              mem_vld;
    cpu_pkg::data_t    rdata;

    assign req_vld[cpu_pkg::REQ_HOST] = host_vld;
    assign reqs[cpu_pkg::REQ_HOST]    = host_req; // host wins every conflict.

    cpu_ctrl u_ctrl (
        .clk        ( clk                         ),
        .rst        ( rst                         ),
        .run        ( run                         ),
        .gnt_fetch  ( gnt[cpu_pkg::REQ_FETCH]     ),
        .rvld_fetch ( rvld[cpu_pkg::REQ_FETCH]    ),
        .gnt_stack  ( gnt[cpu_pkg::REQ_STACK]     ),
        .rvld_stack ( rvld[cpu_pkg::REQ_STACK]    ),
        .rdata      ( rdata                       ),
        .fetch_vld  ( req_vld[cpu_pkg::REQ_FETCH] ),
        .stack_vld  ( req_vld[cpu_pkg::REQ_STACK] ),
        .fetch_req  ( reqs[cpu_pkg::REQ_FETCH]    ),
        .stack_req  ( reqs[cpu_pkg::REQ_STACK]    ),
        .regs       ( regs                        ),
        .pc         ( pc                          ),
        .retire     ( retire                      ),
        .retired    ( retired                     )
    );

    mem_arbiter #(.N_REQ(N_REQ), .req_type(cpu_pkg::mem_req_t)) u_arb (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .req_vld ( req_vld ),
        .req     ( reqs    ),
        .gnt     ( gnt     ),
        .rvld    ( rvld    ),
        .mem_vld ( mem_vld ),
        .mem_req ( mem_req )
    );

    prog_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
        .clk   ( clk     ),
        .vld   ( mem_vld ),
        .req   ( mem_req ),
        .rdata ( rdata   )
    );

endmodule

//--- cpu_ctrl.sv
// register file and pc of the CPU; PC resets to zero, there is no reset vector.
`timescale 1ns/1ps

module cpu_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic              gnt_fetch,
    input  logic              rvld_fetch,
    input  logic              gnt_stack,
    input  logic              rvld_stack,
    input  cpu_pkg::data_t    rdata,
    output logic              fetch_vld,
    output logic              stack_vld,
    output cpu_pkg::mem_req_t fetch_req,
    output cpu_pkg::mem_req_t stack_req,
    output cpu_pkg::regs_t    regs,
    output cpu_pkg::addr_t    pc,
    output logic              retire,
    output cpu_pkg::retire_t  retired
);

    logic           stk_start;
    logic           stk_pull;
    logic           stk_done;
    logic           stk_busy;
    logic [2:0]     stk_mask;
    cpu_pkg::addr_t operand;
    cpu_pkg::addr_t sp_out;
    cpu_pkg::regs_t pulled;
    cpu_pkg::data_t total;
    logic           pc_load;
    logic           pc_step;
    logic           a_load;
    logic           b_load;
    logic           sum;
    logic           s_load;

    assign total = regs.a + regs.b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= '0;
            regs.a  <= '0;
            regs.b  <= '0;
            regs.cc <= '0;
            regs.s  <= cpu_pkg::STACK_TOP;
        end else begin
            if (pc_load)      pc <= operand;
            else if (pc_step) pc <= pc + 16'd1;
            if (a_load) regs.a <= operand[7:0];
            if (b_load) regs.b <= operand[7:0];
            if (sum) begin
                regs.a                <= total;
                regs.cc[cpu_pkg::CC_Z] <= (total == 8'h00);
                regs.cc[cpu_pkg::CC_N] <= total[7];
            end
            if (s_load) begin
                regs.s <= sp_out;
                if (stk_pull && stk_mask[0]) regs.cc <= pulled.cc;
                if (stk_pull && stk_mask[1]) regs.a  <= pulled.a;
                if (stk_pull && stk_mask[2]) regs.b  <= pulled.b;
            end
        end
    end

    cpu_seq u_seq (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .run       ( run        ),
        .regs      ( regs       ),
        .pc        ( pc         ),
        .gnt       ( gnt_fetch  ),
        .rvld      ( rvld_fetch ),
        .rdata     ( rdata      ),
        .stk_done  ( stk_done   ),
        .req_vld   ( fetch_vld  ),
        .req       ( fetch_req  ),
        .stk_start ( stk_start  ),
        .stk_pull  ( stk_pull   ),
        .stk_mask  ( stk_mask   ),
        .operand   ( operand    ),
        .pc_load   ( pc_load    ),
        .pc_step   ( pc_step    ),
        .a_load    ( a_load     ),
        .b_load    ( b_load     ),
        .sum       ( sum        ),
        .s_load    ( s_load     ),
        .retire    ( retire     ),
        .retired   ( retired    )
    );

    stack_engine u_stack (
        .clk     ( clk        ),
        .rst     ( rst        ),
        .start   ( stk_start  ),
        .pull    ( stk_pull   ),
        .mask    ( stk_mask   ),
        .sp_in   ( regs.s     ),
        .regs    ( regs       ),
        .gnt     ( gnt_stack  ),
        .rvld    ( rvld_stack ),
        .rdata   ( rdata      ),
        .req_vld ( stack_vld  ),
        .req     ( stack_req  ),
        .done    ( stk_done   ),
        .sp_out  ( sp_out     ),
        .pulled  ( pulled     ),
        .busy    ( stk_busy   )
    );

    // the core stops fetching while the stack engine owns the bus.
    a_fetch_idle : assert property (@(posedge clk) disable iff (rst) stk_busy |-> !fetch_vld);

endmodule

//--- cpu_seq.sv
// instruction sequencer; fetches only while run is high and treats unknown opcodes as NOP.
`timescale 1ns/1ps

module cpu_seq (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  cpu_pkg::regs_t    regs,
    input  cpu_pkg::addr_t    pc,
    input  logic              gnt,
    input  logic              rvld,
    input  cpu_pkg::data_t    rdata,
    input  logic              stk_done,
    output logic              req_vld,
    output cpu_pkg::mem_req_t req,
    output logic              stk_start,
    output logic              stk_pull,
    output logic [2:0]        stk_mask,
    output cpu_pkg::addr_t    operand,
    output logic              pc_load,
    output logic              pc_step,
    output logic              a_load,
    output logic              b_load,
    output logic              sum,
    output logic              s_load,
    output logic              retire,
    output cpu_pkg::retire_t  retired
);

    typedef enum logic [2:0] {
        S_FETCH, S_OPW, S_OPND, S_OPNDW, S_EXEC, S_STACK
    } state_e;

    state_e         state;
    logic [1:0]     cnt;    // operand bytes still to fetch.
    cpu_pkg::data_t op_q;
    cpu_pkg::addr_t opnd_q;
    cpu_pkg::addr_t op_pc;
    logic           exec;
    logic           is_stk;
    logic           is_br;
    logic           taken;

    // operand bytes that follow each opcode.
    function automatic logic [1:0] opnd_len(cpu_pkg::data_t op);
        case (op)
            cpu_pkg::OP_LDA, cpu_pkg::OP_LDB, cpu_pkg::OP_BRA, cpu_pkg::OP_BEQ,
            cpu_pkg::OP_BNE, cpu_pkg::OP_PSH, cpu_pkg::OP_PUL: return 2'd1;
            cpu_pkg::OP_JMP: return 2'd2;
            default:         return 2'd0;
        endcase
    endfunction

    // ########################################################################
    // state machine
    // ########################################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_FETCH;
            cnt   <= 2'd0;
        end else begin
            case (state)
                S_FETCH: if (gnt) state <= S_OPW;
                S_OPW: if (rvld) begin
                    cnt   <= opnd_len(rdata);
                    state <= (opnd_len(rdata) == 2'd0) ? S_EXEC : S_OPND;
                end
                S_OPND: if (gnt) state <= S_OPNDW;
                S_OPNDW: if (rvld) begin
                    cnt   <= cnt - 2'd1;
                    state <= (cnt == 2'd1) ? S_EXEC : S_OPND;
                end
                S_EXEC:  state <= is_stk ? S_STACK : S_FETCH;
                default: if (stk_done) state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && gnt) op_pc <= pc;
        if (state == S_OPW && rvld) begin
            op_q   <= rdata;
            opnd_q <= '0;
        end
        if (state == S_OPNDW && rvld) opnd_q <= {opnd_q[7:0], rdata}; // high byte first.
    end

    // ########################################################################
    // requests and update strobes
    // ########################################################################
    assign req_vld   = run && (state == S_FETCH || state == S_OPND);
    assign req.we    = 1'b0;
    assign req.addr  = pc;
    assign req.wdata = '0;
    assign pc_step   = rvld && (state == S_OPW || state == S_OPNDW); // one step per byte.

    assign exec   = (state == S_EXEC);
    assign is_stk = (op_q == cpu_pkg::OP_PSH) || (op_q == cpu_pkg::OP_PUL);
    assign is_br  = (op_q == cpu_pkg::OP_BRA) || (op_q == cpu_pkg::OP_BEQ) ||
                    (op_q == cpu_pkg::OP_BNE);
    assign taken  = (op_q == cpu_pkg::OP_BRA) ||
                    (op_q == cpu_pkg::OP_BEQ &&  regs.cc[cpu_pkg::CC_Z]) ||
                    (op_q == cpu_pkg::OP_BNE && !regs.cc[cpu_pkg::CC_Z]);

    // pc already points past the offset here.
    assign operand = is_br ? pc + {{8{opnd_q[7]}}, opnd_q[7:0]} : opnd_q;

    assign pc_load   = exec && ((op_q == cpu_pkg::OP_JMP) || taken);
    assign a_load    = exec && (op_q == cpu_pkg::OP_LDA);
    assign b_load    = exec && (op_q == cpu_pkg::OP_LDB);
    assign sum       = exec && (op_q == cpu_pkg::OP_ADD);
    assign stk_start = exec && is_stk;
    assign stk_pull  = (op_q == cpu_pkg::OP_PUL);
    assign stk_mask  = opnd_q[2:0];
    assign s_load    = (state == S_STACK) && stk_done;

    assign retire     = (exec && !is_stk) || s_load;
    assign retired.pc = op_pc;
    assign retired.op = op_q;

endmodule

//--- stack_engine.sv
// push and pull of CC, A and B by mask; start must not come while busy.
`timescale 1ns/1ps

module stack_engine (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              pull,
    input  logic [2:0]        mask,   // bit 0 cc, bit 1 a, bit 2 b.
    input  cpu_pkg::addr_t    sp_in,
    input  cpu_pkg::regs_t    regs,
    input  logic              gnt,
    input  logic              rvld,
    input  cpu_pkg::data_t    rdata,
    output logic              req_vld,
    output cpu_pkg::mem_req_t req,
    output logic              done,
    output cpu_pkg::addr_t    sp_out,
    output cpu_pkg::regs_t    pulled,
    output logic              busy
);

    logic [2:0]     mask_q;
    logic [2:0]     cur;    // one-hot bit being moved.
    logic           pull_q;
    logic           wait_q; // pull read in flight.
    cpu_pkg::addr_t sp_q;
    cpu_pkg::data_t wbyte;

    // pushes go from the top bit down, pulls from the bottom bit up.
    always_comb begin
        cur = 3'b000;
        if (pull_q) begin
            if (mask_q[0])      cur = 3'b001;
            else if (mask_q[1]) cur = 3'b010;
            else if (mask_q[2]) cur = 3'b100;
        end else begin
            if (mask_q[2])      cur = 3'b100;
            else if (mask_q[1]) cur = 3'b010;
            else if (mask_q[0]) cur = 3'b001;
        end
        case (cur)
            3'b100:  wbyte = regs.b;
            3'b010:  wbyte = regs.a;
            default: wbyte = regs.cc;
        endcase
    end

    assign req_vld   = busy && (mask_q != 3'b000) && !wait_q;
    assign req.we    = !pull_q;
    assign req.addr  = pull_q ? sp_q : sp_q - 16'd1; // pre-decrement on push.
    assign req.wdata = wbyte;
    assign done      = busy && (mask_q == 3'b000) && !wait_q;
    assign sp_out    = sp_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            mask_q <= 3'b000;
            pull_q <= 1'b0;
            wait_q <= 1'b0;
        end else if (start) begin
            busy   <= 1'b1;
            mask_q <= mask;
            pull_q <= pull;
        end else if (done) begin
            busy <= 1'b0;
        end else if (pull_q) begin
            if (req_vld && gnt) wait_q <= 1'b1;
            if (rvld) begin
                wait_q <= 1'b0;
                mask_q <= mask_q & ~cur;
            end
        end else if (req_vld && gnt) begin
            mask_q <= mask_q & ~cur;
        end
    end

    // working s and collected bytes.
    always_ff @(posedge clk) begin
        if (start) begin
            sp_q <= sp_in;
        end else if (req_vld && gnt) begin
            sp_q <= pull_q ? sp_q + 16'd1 : sp_q - 16'd1;
        end
        if (busy && pull_q && rvld) begin
            if (cur[0]) pulled.cc <= rdata;
            if (cur[1]) pulled.a  <= rdata;
            if (cur[2]) pulled.b  <= rdata;
        end
        pulled.s <= sp_q;
    end

    a_no_restart : assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

//--- prog_ram.sv
// single port RAM, one cycle read latency; addresses wrap modulo RAM_DEPTH.
`timescale 1ns/1ps

module prog_ram #(
    parameter int RAM_DEPTH = 1024
) (
    input  logic              clk,
    input  logic              vld,
    input  cpu_pkg::mem_req_t req,
    output cpu_pkg::data_t    rdata
);

    cpu_pkg::data_t mem [RAM_DEPTH];
    int unsigned    idx;

    assign idx = int'(req.addr) % RAM_DEPTH;

    always_ff @(posedge clk) begin
        if (vld) begin
            if (req.we) begin
                mem[idx] <= req.wdata; // host or stack write.
            end else begin
                rdata <= mem[idx];     // valid on the next cycle.
            end
        end
    end

endmodule

//--- mem_arbiter.sv
// fixed priority, one grant per cycle, no queueing; a losing requester must strobe again.
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int  N_REQ    = 3,
    parameter type req_type = logic
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [N_REQ-1:0]   req_vld,
    input  req_type            req [N_REQ],
    output logic [N_REQ-1:0]   gnt,
    output logic [N_REQ-1:0]   rvld,
    output logic               mem_vld,
    output req_type            mem_req
);

    // lowest active index takes the memory this cycle.
    always_comb begin
        logic found;
        found   = 1'b0;
        gnt     = '0;
        mem_req = req[0];
        for (int i = 0; i < N_REQ; i++) begin
            if (req_vld[i] && !found) begin
                gnt[i]  = 1'b1;
                mem_req = req[i];
                found   = 1'b1;
            end
        end
    end

    assign mem_vld = |req_vld;

    // read data comes back one cycle later, so the winner is kept for that cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvld <= '0;
        end else begin
            rvld <= gnt;
        end
    end

    a_one_grant : assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));

endmodule

//--- cpu_pkg.sv
// shared types for the 8-bit CPU; the opcode values are fixed and any other byte runs as NOP.
package cpu_pkg;

    typedef logic [15:0] addr_t; // byte address.
    typedef logic [7:0]  data_t; // memory and register byte.

    // ########################################################################
    // instruction set
    // ########################################################################
    typedef enum logic [7:0] {
        OP_NOP = 8'h12,
        OP_LDA = 8'h86, // lda #imm.
        OP_LDB = 8'hc6, // ldb #imm.
        OP_ADD = 8'h3a, // a = a + b, sets z and n.
        OP_BRA = 8'h20,
        OP_BNE = 8'h26,
        OP_BEQ = 8'h27,
        OP_JMP = 8'h7e, // absolute, high byte first.
        OP_PSH = 8'h34,
        OP_PUL = 8'h35
    } opcode_e;

    // condition byte flag positions.
    localparam int CC_Z = 2;
    localparam int CC_N = 3;

    // ########################################################################
    // bus and state records
    // ########################################################################
    typedef struct packed {
        logic  we;    // write when set.
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        data_t a;
        data_t b;
        data_t cc;
        addr_t s;
    } regs_t;

    typedef struct packed {
        addr_t pc; // address of the opcode byte.
        data_t op;
    } retire_t;

    // arbiter ports, lowest index wins.
    localparam int REQ_HOST  = 0;
    localparam int REQ_STACK = 1;
    localparam int REQ_FETCH = 2;

    localparam addr_t STACK_TOP = 16'h00ff; // s after reset.

endpackage
